//--- common/hex_oled_pkg.sv
package hex_oled_pkg;

    // Panel geometry in pixels.
    localparam int X_SIZE = 96;
    localparam int Y_SIZE = 64;

    // Character cell; glyph fills columns 0..4 and rows 0..6.
    localparam int CELL_W = 6;
    localparam int CELL_H = 8;
    localparam int TEXT_COLS = X_SIZE / CELL_W;

    localparam int DATA_BITS = 128;
    localparam int HALF_BITS = DATA_BITS / 2; // One text row.

    // RGB565 colours.
    localparam int COLOR_BITS = 16;
    localparam logic [COLOR_BITS-1:0] FG_COLOR = 16'h07E0;
    localparam logic [COLOR_BITS-1:0] BG_COLOR = 16'h0000;

    // Panel reset timing in clocks.
    localparam int RESET_CYCLES = 64;
    localparam int DELAY_BITS = $clog2(RESET_CYCLES);
    localparam logic [DELAY_BITS-1:0] DELAY_LAST = DELAY_BITS'(RESET_CYCLES - 1);

    localparam int INIT_SIZE = 13;

    typedef enum logic [1:0] {
        st_reset_low,
        st_reset_wait,
        st_init,
        st_pixels
    } drv_state_t;

endpackage

//--- hex_render/hex_glyph_rom.sv
`timescale 1ns/10ps

module hex_glyph_rom
(
    input  logic       clk,
    input  logic [3:0] digit,
    input  logic [2:0] glyph_row,
    output logic [4:0] row_bits
);

    logic [34:0] glyph; // Row 0 in the top five bits.

    always_comb
    begin
        case (digit)
            4'h0: glyph = {5'h0E, 5'h11, 5'h13, 5'h15, 5'h19, 5'h11, 5'h0E};
            4'h1: glyph = {5'h04, 5'h0C, 5'h04, 5'h04, 5'h04, 5'h04, 5'h0E};
            4'h2: glyph = {5'h0E, 5'h11, 5'h01, 5'h02, 5'h04, 5'h08, 5'h1F};
            4'h3: glyph = {5'h1F, 5'h02, 5'h04, 5'h02, 5'h01, 5'h11, 5'h0E};
            4'h4: glyph = {5'h02, 5'h06, 5'h0A, 5'h12, 5'h1F, 5'h02, 5'h02};
            4'h5: glyph = {5'h1F, 5'h10, 5'h1E, 5'h01, 5'h01, 5'h11, 5'h0E};
            4'h6: glyph = {5'h06, 5'h08, 5'h10, 5'h1E, 5'h11, 5'h11, 5'h0E};
            4'h7: glyph = {5'h1F, 5'h01, 5'h02, 5'h04, 5'h08, 5'h08, 5'h08};
            4'h8: glyph = {5'h0E, 5'h11, 5'h11, 5'h0E, 5'h11, 5'h11, 5'h0E};
            4'h9: glyph = {5'h0E, 5'h11, 5'h11, 5'h0F, 5'h01, 5'h02, 5'h0C};
            4'hA: glyph = {5'h0E, 5'h11, 5'h11, 5'h11, 5'h1F, 5'h11, 5'h11};
            4'hB: glyph = {5'h1E, 5'h11, 5'h11, 5'h1E, 5'h11, 5'h11, 5'h1E};
            4'hC: glyph = {5'h0E, 5'h11, 5'h10, 5'h10, 5'h10, 5'h11, 5'h0E};
            4'hD: glyph = {5'h1C, 5'h12, 5'h11, 5'h11, 5'h11, 5'h12, 5'h1C};
            4'hE: glyph = {5'h1F, 5'h10, 5'h10, 5'h1E, 5'h10, 5'h10, 5'h1F};
            default: glyph = {5'h1F, 5'h10, 5'h10, 5'h1E, 5'h10, 5'h10, 5'h10};
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (glyph_row == 3'd7)
            row_bits <= 5'b0; // Spacing row.
        else
            row_bits <= glyph[(6 - int'(glyph_row)) * 5 +: 5];
    end

endmodule

//--- hex_render/hex_pixel_render.sv
`timescale 1ns/10ps

module hex_pixel_render
    import hex_oled_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [6:0]            pix_x,
    input  logic [5:0]            pix_y,
    input  logic                  frame_start,
    input  logic [DATA_BITS-1:0]  display_value,
    output logic [COLOR_BITS-1:0] pix_color
);

    logic [DATA_BITS-1:0] snapshot;
    logic [HALF_BITS-1:0] half;
    logic [3:0]           text_col;
    logic [2:0]           text_row;
    logic [2:0]           cell_x;
    logic [2:0]           glyph_row;
    logic [3:0]           digit;
    logic                 row_used;
    logic [4:0]           row_bits;
    logic [2:0]           cell_x_d;
    logic                 row_used_d;
    logic                 glyph_bit;

    always_comb
    begin
        text_col  = 4'(pix_x / 7'(CELL_W));
        cell_x    = 3'(pix_x % 7'(CELL_W));
        text_row  = 3'(pix_y / 6'(CELL_H));
        glyph_row = 3'(pix_y % 6'(CELL_H));
        row_used  = (text_row < 3'd2);
        // Row 0 shows the upper half, leftmost digit most significant.
        half  = text_row[0] ? snapshot[HALF_BITS-1:0] : snapshot[DATA_BITS-1:HALF_BITS];
        digit = half[(TEXT_COLS - 1 - int'(text_col)) * 4 +: 4];
    end

    hex_glyph_rom hex_glyph_rom_inst
    (
        .clk       (clk),
        .digit     (digit),
        .glyph_row (glyph_row),
        .row_bits  (row_bits)
    );

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            snapshot   <= '0;
            row_used_d <= 1'b0;
        end
        else
        begin
            if (frame_start)
                snapshot <= display_value; // Held for the whole frame.
            row_used_d <= row_used;
        end
    end

    // Bit 4 of row_bits is the leftmost pixel.
    assign glyph_bit = (cell_x_d < 3'd5) ? row_bits[3'd4 - cell_x_d] : 1'b0;

    always_ff @(posedge clk)
    begin
        cell_x_d  <= cell_x;
        pix_color <= (row_used_d && glyph_bit) ? FG_COLOR : BG_COLOR;
    end

endmodule

//--- logic/hex_oled_top.sv
`timescale 1ns/10ps

module hex_oled_top
    import hex_oled_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [1:0]  wb_adr,
    input  logic [3:0]  wb_sel,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    output logic        oled_csn,
    output logic        oled_clk,
    output logic        oled_mosi,
    output logic        oled_dc,
    output logic        oled_resn
);

    logic [DATA_BITS-1:0]  display_value;
    logic [COLOR_BITS-1:0] pix_color;
    logic [6:0]            pix_x;
    logic [5:0]            pix_y;
    logic                  frame_start;
    logic [3:0]            init_index;
    logic [7:0]            init_byte;

    wb_display_regs wb_display_regs_inst
    (
        .clk           (clk),
        .rst           (rst),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_sel        (wb_sel),
        .wb_dat_w      (wb_dat_w),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack),
        .display_value (display_value)
    );

    hex_pixel_render hex_pixel_render_inst
    (
        .clk           (clk),
        .rst           (rst),
        .pix_x         (pix_x),
        .pix_y         (pix_y),
        .frame_start   (frame_start),
        .display_value (display_value),
        .pix_color     (pix_color)
    );

    oled_init_rom oled_init_rom_inst
    (
        .init_index (init_index),
        .init_byte  (init_byte)
    );

    oled_spi_driver oled_spi_driver_inst
    (
        .clk         (clk),
        .rst         (rst),
        .init_byte   (init_byte),
        .pix_color   (pix_color),
        .init_index  (init_index),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .frame_start (frame_start),
        .oled_csn    (oled_csn),
        .oled_clk    (oled_clk),
        .oled_mosi   (oled_mosi),
        .oled_dc     (oled_dc),
        .oled_resn   (oled_resn)
    );

endmodule

//--- logic/wb_display_regs.sv
`timescale 1ns/10ps

module wb_display_regs
    import hex_oled_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [1:0]           wb_adr,
    input  logic [3:0]           wb_sel,
    input  logic [31:0]          wb_dat_w,
    output logic [31:0]          wb_dat_r,
    output logic                 wb_ack,
    output logic [DATA_BITS-1:0] display_value
);

    logic [31:0] regs [4];
    logic        access;

    // First cycle of a transfer; ack rises on this edge.
    assign access = wb_cyc && wb_stb && !wb_ack;

    assign display_value = {regs[3], regs[2], regs[1], regs[0]};

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wb_ack <= 1'b0;
            for (int i = 0; i < 4; i++)
                regs[i] <= '0;
        end
        else
        begin
            wb_ack <= access;
            if (access && wb_we)
            begin
                for (int b = 0; b < 4; b++)
                    if (wb_sel[b])
                        regs[wb_adr][b*8 +: 8] <= wb_dat_w[b*8 +: 8]; // Byte lanes.
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (access)
            wb_dat_r <= regs[wb_adr];
    end

endmodule

//--- oled_spi/oled_init_rom.sv
`timescale 1ns/10ps

module oled_init_rom
(
    input  logic [3:0] init_index,
    output logic [7:0] init_byte
);

    always_comb
    begin
        case (init_index)
            4'd0:    init_byte = 8'hAE; // Display off.
            4'd1:    init_byte = 8'hA0; // Remap and colour depth.
            4'd2:    init_byte = 8'h72;
            4'd3:    init_byte = 8'hA1; // Start line.
            4'd4:    init_byte = 8'h00;
            4'd5:    init_byte = 8'hA2; // Display offset.
            4'd6:    init_byte = 8'h00;
            4'd7:    init_byte = 8'hA4; // Normal display.
            4'd8:    init_byte = 8'hA8; // Multiplex ratio.
            4'd9:    init_byte = 8'h3F;
            4'd10:   init_byte = 8'hAD; // Master config.
            4'd11:   init_byte = 8'h8E;
            4'd12:   init_byte = 8'hAF; // Display on.
            default: init_byte = 8'h00;
        endcase
    end

endmodule

//--- oled_spi/oled_spi_driver.sv
`timescale 1ns/10ps

module oled_spi_driver
    import hex_oled_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [7:0]            init_byte,
    input  logic [COLOR_BITS-1:0] pix_color,
    output logic [3:0]            init_index,
    output logic [6:0]            pix_x,
    output logic [5:0]            pix_y,
    output logic                  frame_start,
    output logic                  oled_csn,
    output logic                  oled_clk,
    output logic                  oled_mosi,
    output logic                  oled_dc,
    output logic                  oled_resn
);

    drv_state_t            state;
    logic [DELAY_BITS-1:0] delay_cnt;
    logic [3:0]            bit_cnt;
    logic                  byte_sel; // Low colour byte next.
    logic [7:0]            tx_byte;
    logic [7:0]            color_lo;
    logic [7:0]            next_byte;
    logic                  sending;
    logic                  load;
    logic                  last_x;
    logic                  last_y;

    assign sending = (state == st_init) || (state == st_pixels);
    assign load    = sending && (bit_cnt == 4'd0);
    assign last_x  = (pix_x == 7'(X_SIZE - 1));
    assign last_y  = (pix_y == 6'(Y_SIZE - 1));

    always_comb
    begin
        if (state == st_init)
            next_byte = init_byte;
        else if (byte_sel)
            next_byte = color_lo;
        else
            next_byte = pix_color[15:8];
    end

    // Colour of the previous coordinate, stable for a full pixel slot.
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            tx_byte <= next_byte;
            if (state == st_pixels && !byte_sel)
                color_lo <= pix_color[7:0];
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state       <= st_reset_low;
            delay_cnt   <= '0;
            bit_cnt     <= '0;
            byte_sel    <= 1'b0;
            init_index  <= '0;
            pix_x       <= '0;
            pix_y       <= '0;
            frame_start <= 1'b0;
            oled_csn    <= 1'b1;
            oled_clk    <= 1'b0;
            oled_mosi   <= 1'b0;
            oled_dc     <= 1'b0;
            oled_resn   <= 1'b0;
        end
        else
        begin
            frame_start <= 1'b0;
            case (state)
                st_reset_low:
                begin
                    delay_cnt <= delay_cnt + 1'b1;
                    if (delay_cnt == DELAY_LAST)
                    begin
                        delay_cnt <= '0;
                        oled_resn <= 1'b1;
                        state     <= st_reset_wait;
                    end
                end
                st_reset_wait:
                begin
                    delay_cnt <= delay_cnt + 1'b1;
                    if (delay_cnt == DELAY_LAST)
                    begin
                        oled_csn <= 1'b0; // Selected for good.
                        bit_cnt  <= '0;
                        state    <= st_init;
                    end
                end
                st_init:
                begin
                    // Pixel (0,0) is already presented during the last command.
                    if (bit_cnt == 4'd0 && init_index == 4'(INIT_SIZE - 1))
                        frame_start <= 1'b1;
                    if (bit_cnt == 4'd15)
                    begin
                        if (init_index == 4'(INIT_SIZE - 1))
                            state <= st_pixels;
                        else
                            init_index <= init_index + 1'b1;
                    end
                end
                st_pixels:
                begin
                    if (bit_cnt == 4'd0 && !byte_sel)
                    begin
                        if (last_x)
                        begin
                            pix_x <= '0;
                            pix_y <= last_y ? 6'd0 : pix_y + 1'b1;
                            if (last_y)
                                frame_start <= 1'b1;
                        end
                        else
                        begin
                            pix_x <= pix_x + 1'b1;
                        end
                    end
                    if (bit_cnt == 4'd15)
                        byte_sel <= !byte_sel;
                end
                default: state <= st_reset_low;
            endcase

            // Mode 0 serializer, MSB first.
            if (sending)
            begin
                bit_cnt  <= bit_cnt + 1'b1;
                oled_clk <= bit_cnt[0];
                if (bit_cnt == 4'd0)
                begin
                    oled_mosi <= next_byte[7];
                    oled_dc   <= (state == st_pixels);
                end
                else if (!bit_cnt[0])
                begin
                    oled_mosi <= tx_byte[~bit_cnt[3:1]];
                end
            end
        end
    end

endmodule

//--- project.f
common/hex_oled_pkg.sv
logic/wb_display_regs.sv
hex_render/hex_glyph_rom.sv
hex_render/hex_pixel_render.sv
oled_spi/oled_init_rom.sv
oled_spi/oled_spi_driver.sv
logic/hex_oled_top.sv
tb/oled_spi_monitor.sv
tb/tb_hex_oled.sv

//--- tb/oled_spi_monitor.sv
`timescale 1ns/10ps

module oled_spi_monitor
(
    input  logic oled_csn,
    input  logic oled_clk,
    input  logic oled_mosi,
    input  logic oled_dc
);

    logic [8:0] rx_q [$]; // Received bytes as {dc, data}.
    logic [7:0] shift;
    int         bit_count;
    time        last_time;
    time        max_gap;  // Longest interval between two bytes.
    logic       seen_byte;

    initial
    begin
        shift     = '0;
        bit_count = 0;
        last_time = 0;
        max_gap   = 0;
        seen_byte = 1'b0;
    end

    // Mode 0, so MOSI is stable at each rising edge.
    always @(posedge oled_clk)
    begin
        if (!oled_csn)
        begin
            shift = {shift[6:0], oled_mosi};
            bit_count++;
            if (bit_count == 8)
            begin
                rx_q.push_back({oled_dc, shift});
                bit_count = 0;
                if (seen_byte && ($time - last_time) > max_gap)
                    max_gap = $time - last_time;
                last_time = $time;
                seen_byte = 1'b1;
            end
        end
    end

endmodule

//--- tb/tb_hex_oled.sv
`timescale 1ns/10ps

module tb_hex_oled
    import hex_oled_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int ROWS = 5;
    localparam int FRAME_BYTES = X_SIZE * Y_SIZE * 2;
    localparam longint RUN_CYCLES = 16 + 2 * RESET_CYCLES + INIT_SIZE * 16
                                    + longint'(ROWS + 1) * FRAME_BYTES * 16;
    localparam longint WATCHDOG_NS = RUN_CYCLES * CLK_PERIOD * 11 / 10;

    typedef struct packed {
        logic [1:0]  adr;
        logic [3:0]  sel;
        logic [31:0] data;
        logic        rnd;         // Data drawn from $urandom.
        logic [31:0] expect_word; // Word contents after the write.
    } wb_entry_t;

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [1:0]  wb_adr;
    logic [3:0]  wb_sel;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        oled_csn;
    logic        oled_clk;
    logic        oled_mosi;
    logic        oled_dc;
    logic        oled_resn;

    wb_entry_t            entries [ROWS];
    logic [31:0]          model_words [4];
    logic [31:0]          shown [4];
    logic [7:0]           init_list [INIT_SIZE];
    logic [DATA_BITS-1:0] screen;
    logic [7:0]           rx_byte;
    logic                 rx_dc;
    int                   low_cycles;

    hex_oled_top hex_oled_top_inst
    (
        .clk       (clk),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_sel    (wb_sel),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .oled_csn  (oled_csn),
        .oled_clk  (oled_clk),
        .oled_mosi (oled_mosi),
        .oled_dc   (oled_dc),
        .oled_resn (oled_resn)
    );

    oled_spi_monitor oled_spi_monitor_inst
    (
        .oled_csn  (oled_csn),
        .oled_clk  (oled_clk),
        .oled_mosi (oled_mosi),
        .oled_dc   (oled_dc)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] expected, input string what);
        if (got !== expected)
            report_failure($sformatf("FAILED at %0t: %s got %h expected %h",
                                     $time, what, got, expected));
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] expected,
                              input string what);
        if (got !== expected)
            report_failure($sformatf("FAILED at %0t: %s got %h expected %h",
                                     $time, what, got, expected));
    endtask

    task automatic check_color(input logic [COLOR_BITS-1:0] got,
                               input logic [COLOR_BITS-1:0] expected, input string what);
        if (got !== expected)
            report_failure($sformatf("FAILED at %0t: %s got %h expected %h",
                                     $time, what, got, expected));
    endtask

    // 5x7 hex font, top row first, bit 4 leftmost.
    function automatic logic [4:0] font_row(input logic [3:0] digit, input int row);
        logic [34:0] glyph;
        case (digit)
            4'h0: glyph = {5'h0E, 5'h11, 5'h13, 5'h15, 5'h19, 5'h11, 5'h0E};
            4'h1: glyph = {5'h04, 5'h0C, 5'h04, 5'h04, 5'h04, 5'h04, 5'h0E};
            4'h2: glyph = {5'h0E, 5'h11, 5'h01, 5'h02, 5'h04, 5'h08, 5'h1F};
            4'h3: glyph = {5'h1F, 5'h02, 5'h04, 5'h02, 5'h01, 5'h11, 5'h0E};
            4'h4: glyph = {5'h02, 5'h06, 5'h0A, 5'h12, 5'h1F, 5'h02, 5'h02};
            4'h5: glyph = {5'h1F, 5'h10, 5'h1E, 5'h01, 5'h01, 5'h11, 5'h0E};
            4'h6: glyph = {5'h06, 5'h08, 5'h10, 5'h1E, 5'h11, 5'h11, 5'h0E};
            4'h7: glyph = {5'h1F, 5'h01, 5'h02, 5'h04, 5'h08, 5'h08, 5'h08};
            4'h8: glyph = {5'h0E, 5'h11, 5'h11, 5'h0E, 5'h11, 5'h11, 5'h0E};
            4'h9: glyph = {5'h0E, 5'h11, 5'h11, 5'h0F, 5'h01, 5'h02, 5'h0C};
            4'hA: glyph = {5'h0E, 5'h11, 5'h11, 5'h11, 5'h1F, 5'h11, 5'h11};
            4'hB: glyph = {5'h1E, 5'h11, 5'h11, 5'h1E, 5'h11, 5'h11, 5'h1E};
            4'hC: glyph = {5'h0E, 5'h11, 5'h10, 5'h10, 5'h10, 5'h11, 5'h0E};
            4'hD: glyph = {5'h1C, 5'h12, 5'h11, 5'h11, 5'h11, 5'h12, 5'h1C};
            4'hE: glyph = {5'h1F, 5'h10, 5'h10, 5'h1E, 5'h10, 5'h10, 5'h1F};
            default: glyph = {5'h1F, 5'h10, 5'h10, 5'h1E, 5'h10, 5'h10, 5'h10};
        endcase
        return glyph[(6 - row) * 5 +: 5];
    endfunction

    function automatic logic [COLOR_BITS-1:0] expected_color(input logic [DATA_BITS-1:0] value,
                                                             input int x, input int y);
        int         col;
        int         cx;
        int         trow;
        int         gy;
        logic [3:0] digit;
        logic [4:0] bits;
        col  = x / CELL_W;
        cx   = x % CELL_W;
        trow = y / CELL_H;
        gy   = y % CELL_H;
        if (trow > 1 || cx > 4 || gy > 6)
            return BG_COLOR;
        digit = value[DATA_BITS - 1 - trow * HALF_BITS - col * 4 -: 4]; // MSD on the left.
        bits  = font_row(digit, gy);
        return bits[4 - cx] ? FG_COLOR : BG_COLOR;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] sel);
        logic [31:0] mask;
        mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        return (old & ~mask) | (data & mask);
    endfunction

    task automatic next_spi_byte(output logic [7:0] data, output logic dc);
        logic [8:0] item;
        while (oled_spi_monitor_inst.rx_q.size() == 0)
            @(negedge clk);
        item = oled_spi_monitor_inst.rx_q.pop_front();
        dc   = item[8];
        data = item[7:0];
    endtask

    task automatic wb_access(input logic we, input logic [1:0] adr, input logic [3:0] sel,
                             input logic [31:0] data, output logic [31:0] rdata);
        int waited;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_sel   = sel;
        wb_dat_w = data;
        waited   = 0;
        do
        begin
            @(negedge clk);
            waited++;
            if (waited > 8)
                report_failure("Wishbone access was never acknowledged");
        end
        while (!wb_ack);
        if (waited != 1)
            report_failure("Wishbone ack came later than one clock");
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(negedge clk);
        if (wb_ack)
            report_failure("Wishbone ack stayed high for more than one clock");
    endtask

    task automatic apply_entry(input int idx);
        logic [31:0] rdata;
        wb_access(1'b1, entries[idx].adr, entries[idx].sel, entries[idx].data, rdata);
        wb_access(1'b0, entries[idx].adr, 4'h0, 32'h0, rdata);
        check_word(rdata, entries[idx].expect_word,
                   $sformatf("readback of word %0d", entries[idx].adr));
        shown[entries[idx].adr] = entries[idx].expect_word;
    endtask

    // Checks one frame; a table entry is written just after its first byte.
    task automatic check_frame(input logic [DATA_BITS-1:0] value, input int entry);
        logic [7:0] hi;
        logic [7:0] lo;
        logic       dc;
        for (int y = 0; y < Y_SIZE; y++)
        begin
            for (int x = 0; x < X_SIZE; x++)
            begin
                next_spi_byte(hi, dc);
                if (!dc)
                    report_failure("pixel byte sent with dc low");
                if (x == 0 && y == 0 && entry >= 0)
                    apply_entry(entry);
                next_spi_byte(lo, dc);
                if (!dc)
                    report_failure("pixel byte sent with dc low");
                check_color({hi, lo}, expected_color(value, x, y),
                            $sformatf("pixel (%0d,%0d)", x, y));
            end
        end
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        report_failure("display stream stalled before all frames were checked");
    end

    initial
    begin
        rst        = 1'b1;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_sel     = '0;
        wb_dat_w   = '0;
        void'($urandom(32'h1973));
        init_list  = '{8'hAE, 8'hA0, 8'h72, 8'hA1, 8'h00, 8'hA2, 8'h00,
                       8'hA4, 8'hA8, 8'h3F, 8'hAD, 8'h8E, 8'hAF};

        entries[0] = '{2'd3, 4'hF, 32'h0123_4567, 1'b0, 32'h0123_4567};
        entries[1] = '{2'd2, 4'hF, 32'h89AB_CDEF, 1'b0, 32'h89AB_CDEF};
        entries[2] = '{2'd0, 4'h5, 32'hFEDC_BA98, 1'b0, 32'h00DC_0098};
        entries[3] = '{2'd1, 4'hF, 32'h0, 1'b1, 32'h0};
        entries[4] = '{2'd0, 4'hA, 32'h0, 1'b1, 32'h0};
        for (int i = 0; i < 4; i++)
        begin
            model_words[i] = '0;
            shown[i]       = '0;
        end
        for (int i = 0; i < ROWS; i++)
        begin
            if (entries[i].rnd)
            begin
                entries[i].data        = $urandom;
                entries[i].expect_word = merge_bytes(model_words[entries[i].adr],
                                                     entries[i].data, entries[i].sel);
            end
            model_words[entries[i].adr] = entries[i].expect_word;
        end

        repeat (16) @(negedge clk);
        if (oled_resn !== 1'b0 || oled_csn !== 1'b1 || wb_ack !== 1'b0)
            report_failure("outputs not in their reset state");
        rst        = 1'b0;
        low_cycles = 0;
        while (!oled_resn)
        begin
            @(negedge clk);
            low_cycles++;
            if (low_cycles > 4 * RESET_CYCLES)
                report_failure("oled_resn never went high");
        end
        if (low_cycles != RESET_CYCLES)
            report_failure($sformatf("FAILED at %0t: oled_resn low for %0d clocks",
                                     $time, low_cycles));
        if (oled_spi_monitor_inst.rx_q.size() != 0)
            report_failure("SPI byte sent while the panel was in reset");

        for (int i = 0; i < INIT_SIZE; i++)
        begin
            next_spi_byte(rx_byte, rx_dc);
            if (rx_dc)
                report_failure("init byte sent with dc high");
            check_byte(rx_byte, init_list[i], $sformatf("init byte %0d", i));
        end

        screen = '0;
        for (int i = 0; i < ROWS; i++)
        begin
            check_frame(screen, i);
            screen = {shown[3], shown[2], shown[1], shown[0]};
        end
        check_frame(screen, -1);

        if (oled_spi_monitor_inst.max_gap != 16 * CLK_PERIOD)
            report_failure("gap found between SPI bytes");

        $display("all tests passed");
        $finish;
    end

endmodule
